//--- filelist.f
source/lc_pkg.sv
source/sec_pkg.sv
source/lc_trans_fsm.sv
source/debug_enable_gen.sv
source/lcc_st_trans_top.sv
testbench/lcc_st_trans_assert.sv
testbench/tb_lcc_st_trans.sv

//--- run.sh
#!/bin/sh
# Build and run the lifecycle translator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lcc_st_trans -f filelist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- source/debug_enable_gen.sv
/* SoC debug enable generator */

`timescale 1ns/1ps
`default_nettype none

module debug_enable_gen (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Fuse controller
  input  logic              otp_valid_i,
  // Lifecycle controller
  input  logic              lc_prog_req_i,
  input  lc_pkg::lc_state_t lc_prog_state_i,
  input  lc_pkg::lc_tx_t    lc_dft_en_i,
  input  lc_pkg::lc_tx_t    lc_hw_debug_en_i,
  // Unlock level and SoC masks
  input  sec_pkg::mask_t    unlock_level_i,
  input  sec_pkg::mask_t    dft_mask_i,
  input  sec_pkg::mask_t    dbg_unlock_mask_i,
  input  sec_pkg::mask_t    cltap_mask_i,
  // To the FSM
  output logic              scrap_req_o,
  output logic              prod_unlock_o,
  // SoC enables
  output logic              soc_dft_en_o,
  output logic              soc_hw_debug_en_o
);

  import lc_pkg::*;

  logic dft_unlock;
  logic cltap_unlock;
  logic dft_en_d;
  logic hw_debug_en_d;

  // ----------------------------------------
  // Masked decodes
  // ----------------------------------------

  // Any unlock level hit in a mask counts
  assign dft_unlock    = |(unlock_level_i & dft_mask_i);
  assign cltap_unlock  = |(unlock_level_i & cltap_mask_i);
  assign prod_unlock_o = |(unlock_level_i & dbg_unlock_mask_i);

  // Scrap only when the program request targets scrap
  assign scrap_req_o = lc_prog_req_i & (lc_prog_state_i == LcStScrap);

  // LC enable or mask hit, scrap overrides both
  assign dft_en_d      = ((lc_dft_en_i == LcTxOn) | dft_unlock) & ~scrap_req_o;
  assign hw_debug_en_d = ((lc_hw_debug_en_i == LcTxOn) | cltap_unlock) & ~scrap_req_o;

  // ----------------------------------------
  // Registered enables
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid_i) begin
      soc_dft_en_o      <= dft_en_d;
      soc_hw_debug_en_o <= hw_debug_en_d;
    end else begin
      // Cleared while fuse data is not valid
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/lc_pkg.sv
/* Lifecycle controller encodings */

`default_nettype none

package lc_pkg;

  // ----------------------------------------
  // Lifecycle state code
  // ----------------------------------------

  // Compact code, 21 to 31 are invalid
  typedef logic [4:0] lc_state_t;

  localparam lc_state_t LcStRaw           = 5'd0;
  localparam lc_state_t LcStTestUnlocked0 = 5'd1;
  localparam lc_state_t LcStTestUnlocked1 = 5'd2;
  localparam lc_state_t LcStTestUnlocked2 = 5'd3;
  localparam lc_state_t LcStTestUnlocked3 = 5'd4;
  localparam lc_state_t LcStTestUnlocked4 = 5'd5;
  localparam lc_state_t LcStTestUnlocked5 = 5'd6;
  localparam lc_state_t LcStTestUnlocked6 = 5'd7;
  localparam lc_state_t LcStTestUnlocked7 = 5'd8;
  localparam lc_state_t LcStTestLocked0   = 5'd9;
  localparam lc_state_t LcStTestLocked1   = 5'd10;
  localparam lc_state_t LcStTestLocked2   = 5'd11;
  localparam lc_state_t LcStTestLocked3   = 5'd12;
  localparam lc_state_t LcStTestLocked4   = 5'd13;
  localparam lc_state_t LcStTestLocked5   = 5'd14;
  localparam lc_state_t LcStTestLocked6   = 5'd15;
  localparam lc_state_t LcStDev           = 5'd16;
  localparam lc_state_t LcStProd          = 5'd17;
  localparam lc_state_t LcStProdEnd       = 5'd18;
  localparam lc_state_t LcStRma           = 5'd19;
  localparam lc_state_t LcStScrap         = 5'd20;

  // ----------------------------------------
  // Multibit enable
  // ----------------------------------------

  // Four bit enable from the lifecycle controller
  typedef logic [3:0] lc_tx_t;

  // Only true value, any other pattern reads as off
  localparam lc_tx_t LcTxOn = 4'b0101;

endpackage

`default_nettype wire

//--- source/lc_trans_fsm.sv
/* Lifecycle to security state FSM */

`timescale 1ns/1ps
`default_nettype none

module lc_trans_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Fuse controller
  input  logic                otp_valid_i,
  input  lc_pkg::lc_state_t   otp_state_i,
  // Core side
  input  logic                state_error_i,
  input  logic                dbg_manuf_en_i,
  // Decodes from the enable generator
  input  logic                scrap_req_i,
  input  logic                prod_unlock_i,
  // Security state
  output sec_pkg::lifecycle_t lifecycle_o,
  output logic                debug_locked_o
);

  import lc_pkg::*;
  import sec_pkg::*;

  trans_state_e state_q;
  trans_state_e state_d;
  lc_state_t    otp_state_q;
  lifecycle_t   lifecycle_d;
  logic         debug_locked_d;
  logic         kill_req;

  // Either source forces the locked class
  assign kill_req = scrap_req_i | state_error_i;

  // ----------------------------------------
  // Fuse state classification
  // ----------------------------------------

  // Entry class for a latched fuse state
  function automatic trans_state_e classify(lc_state_t st);
    trans_state_e cls;
    case (st)
      LcStRaw,
      LcStTestLocked0,
      LcStTestLocked1,
      LcStTestLocked2,
      LcStTestLocked3,
      LcStTestLocked4,
      LcStTestLocked5,
      LcStTestLocked6,
      LcStScrap: begin
        cls = TransNonDebug;
      end
      LcStTestUnlocked0,
      LcStTestUnlocked1,
      LcStTestUnlocked2,
      LcStTestUnlocked3,
      LcStTestUnlocked4,
      LcStTestUnlocked5,
      LcStTestUnlocked6,
      LcStTestUnlocked7: begin
        cls = TransUnprovDebug;
      end
      LcStDev: begin
        cls = TransManufNonDebug;
      end
      LcStProd,
      LcStProdEnd: begin
        cls = TransProdNonDebug;
      end
      LcStRma: begin
        cls = TransProdDebug;
      end
      // Invalid code, wait in idle
      default: begin
        cls = TransIdle;
      end
    endcase
    return cls;
  endfunction

  // ----------------------------------------
  // Next state and class outputs
  // ----------------------------------------

  always_comb begin
    state_d        = state_q;
    // Production locked unless a class says otherwise
    lifecycle_d    = DevProduction;
    debug_locked_d = 1'b1;
    case (state_q)
      TransReset: begin
        state_d = TransIdle;
      end
      TransIdle: begin
        if (kill_req) begin
          state_d = TransNonDebug;
        end else begin
          state_d = classify(otp_state_q);
        end
      end
      TransNonDebug: begin
        // Sticky
        state_d = TransNonDebug;
      end
      TransUnprovDebug: begin
        if (kill_req) begin
          state_d = TransNonDebug;
        end else begin
          lifecycle_d    = DevUnprovisioned;
          debug_locked_d = 1'b0;
        end
      end
      TransManufNonDebug: begin
        if (kill_req) begin
          state_d = TransNonDebug;
        end else begin
          lifecycle_d = DevManufacturing;
          // Unlock shows one edge after the move
          if (dbg_manuf_en_i) begin
            state_d = TransManufDebug;
          end
        end
      end
      TransManufDebug: begin
        if (kill_req) begin
          state_d = TransNonDebug;
        end else begin
          lifecycle_d    = DevManufacturing;
          debug_locked_d = 1'b0;
        end
      end
      TransProdNonDebug: begin
        if (kill_req) begin
          state_d = TransNonDebug;
        end else if (prod_unlock_i) begin
          state_d = TransProdDebug;
        end
      end
      TransProdDebug: begin
        if (kill_req) begin
          state_d = TransNonDebug;
        end else begin
          debug_locked_d = 1'b0;
        end
      end
      default: begin
        state_d = TransReset;
      end
    endcase
  end

  // ----------------------------------------
  // Registers, gated by the valid level
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= TransReset;
      otp_state_q    <= LcStRaw;
      lifecycle_o    <= DevProduction;
      debug_locked_o <= 1'b1;
    end else if (otp_valid_i) begin
      state_q        <= state_d;
      // Fuse state is static, sample it once on leaving reset
      if (state_q == TransReset) begin
        otp_state_q <= otp_state_i;
      end
      lifecycle_o    <= lifecycle_d;
      debug_locked_o <= debug_locked_d;
    end else begin
      // Valid low restarts the sequence
      state_q        <= TransReset;
      otp_state_q    <= LcStRaw;
      lifecycle_o    <= DevProduction;
      debug_locked_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/lcc_st_trans_top.sv
/* Lifecycle state translator top */

`timescale 1ns/1ps
`default_nettype none

module lcc_st_trans_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Fuse controller
  input  logic                otp_valid_i,
  input  lc_pkg::lc_state_t   otp_state_i,
  // Lifecycle controller
  input  logic                lc_prog_req_i,
  input  lc_pkg::lc_state_t   lc_prog_state_i,
  input  lc_pkg::lc_tx_t      lc_dft_en_i,
  input  lc_pkg::lc_tx_t      lc_hw_debug_en_i,
  // Core and SoC
  input  logic                state_error_i,
  input  logic                dbg_manuf_en_i,
  input  sec_pkg::mask_t      unlock_level_i,
  input  sec_pkg::mask_t      dft_mask_i,
  input  sec_pkg::mask_t      dbg_unlock_mask_i,
  input  sec_pkg::mask_t      cltap_mask_i,
  // SoC enables
  output logic                soc_dft_en_o,
  output logic                soc_hw_debug_en_o,
  // Core security state
  output sec_pkg::lifecycle_t lifecycle_o,
  output logic                debug_locked_o
);

  // Combinational decodes into the FSM
  logic scrap_req;
  logic prod_unlock;

  // ----------------------------------------
  // Translator FSM
  // ----------------------------------------

  lc_trans_fsm lc_trans_fsm_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .otp_valid_i    (otp_valid_i),
    .otp_state_i    (otp_state_i),
    .state_error_i  (state_error_i),
    .dbg_manuf_en_i (dbg_manuf_en_i),
    .scrap_req_i    (scrap_req),
    .prod_unlock_i  (prod_unlock),
    .lifecycle_o    (lifecycle_o),
    .debug_locked_o (debug_locked_o)
  );

  // ----------------------------------------
  // Mask decode and SoC enables
  // ----------------------------------------

  debug_enable_gen debug_enable_gen_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .otp_valid_i       (otp_valid_i),
    .lc_prog_req_i     (lc_prog_req_i),
    .lc_prog_state_i   (lc_prog_state_i),
    .lc_dft_en_i       (lc_dft_en_i),
    .lc_hw_debug_en_i  (lc_hw_debug_en_i),
    .unlock_level_i    (unlock_level_i),
    .dft_mask_i        (dft_mask_i),
    .dbg_unlock_mask_i (dbg_unlock_mask_i),
    .cltap_mask_i      (cltap_mask_i),
    .scrap_req_o       (scrap_req),
    .prod_unlock_o     (prod_unlock),
    .soc_dft_en_o      (soc_dft_en_o),
    .soc_hw_debug_en_o (soc_hw_debug_en_o)
  );

endmodule

`default_nettype wire

//--- source/sec_pkg.sv
/* Security state types */

`default_nettype none

package sec_pkg;

  // ----------------------------------------
  // Device lifecycle seen by the core
  // ----------------------------------------

  typedef logic [1:0] lifecycle_t;

  localparam lifecycle_t DevUnprovisioned = 2'd0;
  localparam lifecycle_t DevManufacturing = 2'd1;
  localparam lifecycle_t DevProduction    = 2'd2;

  // ----------------------------------------
  // Translator FSM states
  // ----------------------------------------

  typedef enum logic [2:0] {
    TransReset,
    TransIdle,
    // Sticky locked class, left only by a valid drop
    TransNonDebug,
    TransUnprovDebug,
    TransManufNonDebug,
    TransManufDebug,
    TransProdNonDebug,
    TransProdDebug
  } trans_state_e;

  // ----------------------------------------
  // Unlock level and SoC masks
  // ----------------------------------------

  localparam int unsigned MaskW = 64;

  // One bit per unlock level
  typedef logic [MaskW-1:0] mask_t;

endpackage

`default_nettype wire

//--- testbench/lcc_st_trans_assert.sv
/* Translator FSM assertions */

`timescale 1ns/1ps
`default_nettype none

module lcc_st_trans_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  otp_valid_i,
  input logic                  state_error_i,
  input sec_pkg::trans_state_e state_i,
  input sec_pkg::lifecycle_t   lifecycle_i,
  input logic                  debug_locked_i
);

  import sec_pkg::*;

  // Locked class holds while fuse data stays valid
  sticky_non_debug: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (otp_valid_i && state_i == TransNonDebug) |=> (state_i == TransNonDebug)
  ) else $error("Non-debug class left while valid was high");

  // One edge of valid low restores reset outputs
  reset_on_invalid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !otp_valid_i |=> (lifecycle_i == DevProduction && debug_locked_i)
  ) else $error("Outputs not at reset values after valid low");

  // Error held over two edges, debug stays locked
  locked_on_error: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_error_i && $past(state_error_i)) |-> debug_locked_i
  ) else $error("Debug unlocked during a held state error");

endmodule

bind lc_trans_fsm lcc_st_trans_assert lcc_st_trans_assert_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .otp_valid_i    (otp_valid_i),
  .state_error_i  (state_error_i),
  .state_i        (state_q),
  .lifecycle_i    (lifecycle_o),
  .debug_locked_i (debug_locked_o)
);

`default_nettype wire

//--- testbench/tb_lcc_st_trans.sv
/* Lifecycle translator testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_lcc_st_trans;

  import lc_pkg::*;
  import sec_pkg::*;

  // One stimulus row and its expected outputs
  typedef struct packed {
    lc_state_t  otp_state;
    logic       manuf_en;
    mask_t      unlock;
    mask_t      dft_mask;
    mask_t      dbg_mask;
    mask_t      cltap_mask;
    lc_tx_t     dft_en;
    lc_tx_t     hw_en;
    logic       prog_req;
    lc_state_t  prog_state;
    logic       error;
    lifecycle_t exp_lc;
    logic       exp_locked;
    logic       exp_dft;
    logic       exp_hw;
  } row_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       otp_valid;
  lc_state_t  otp_state;
  logic       lc_prog_req;
  lc_state_t  lc_prog_state;
  lc_tx_t     lc_dft_en;
  lc_tx_t     lc_hw_debug_en;
  logic       state_error;
  logic       dbg_manuf_en;
  mask_t      unlock_level;
  mask_t      dft_mask;
  mask_t      dbg_unlock_mask;
  mask_t      cltap_mask;
  logic       soc_dft_en;
  logic       soc_hw_debug_en;
  lifecycle_t lifecycle;
  logic       debug_locked;

  row_t   rows[$];
  row_t   r;
  mask_t  m;
  integer seed;
  int     row_idx;
  logic   verdict_printed;

  lcc_st_trans_top lcc_st_trans_top_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .otp_valid_i       (otp_valid),
    .otp_state_i       (otp_state),
    .lc_prog_req_i     (lc_prog_req),
    .lc_prog_state_i   (lc_prog_state),
    .lc_dft_en_i       (lc_dft_en),
    .lc_hw_debug_en_i  (lc_hw_debug_en),
    .state_error_i     (state_error),
    .dbg_manuf_en_i    (dbg_manuf_en),
    .unlock_level_i    (unlock_level),
    .dft_mask_i        (dft_mask),
    .dbg_unlock_mask_i (dbg_unlock_mask),
    .cltap_mask_i      (cltap_mask),
    .soc_dft_en_o      (soc_dft_en),
    .soc_hw_debug_en_o (soc_hw_debug_en),
    .lifecycle_o       (lifecycle),
    .debug_locked_o    (debug_locked)
  );

  // 8 ns clock
  initial begin
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Row with masks, enables and kill sources cleared
  function automatic row_t make_row(lc_state_t st, logic manuf, lifecycle_t lc, logic locked,
                                    logic dft, logic hw);
    row_t t;
    t            = '0;
    t.otp_state  = st;
    t.manuf_en   = manuf;
    t.exp_lc     = lc;
    t.exp_locked = locked;
    t.exp_dft    = dft;
    t.exp_hw     = hw;
    return t;
  endfunction

  task automatic drive_row(input row_t t);
    otp_state       = t.otp_state;
    dbg_manuf_en    = t.manuf_en;
    unlock_level    = t.unlock;
    dft_mask        = t.dft_mask;
    dbg_unlock_mask = t.dbg_mask;
    cltap_mask      = t.cltap_mask;
    lc_dft_en       = t.dft_en;
    lc_hw_debug_en  = t.hw_en;
    lc_prog_req     = t.prog_req;
    lc_prog_state   = t.prog_state;
    state_error     = t.error;
  endtask

  task automatic stop_on_error();
    verdict_printed = 1'b1;
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_lifecycle(input string name, input lifecycle_t got,
                                 input lifecycle_t exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic wait_edges(input int n);
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
    end
  endtask

  // Valid low must clear the outputs within two edges
  task automatic wait_reset_values();
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      n++;
      done = (lifecycle == DevProduction) && debug_locked && !soc_dft_en && !soc_hw_debug_en;
      if (!done && n >= 2) begin
        $display("Outputs did not return to reset values within two edges of valid low");
        stop_on_error();
      end
    end
    if (n < 2) begin
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // Stimulus table and main loop
  // ----------------------------------------

  initial begin
    seed            = 53;
    verdict_printed = 1'b0;
    row_idx         = 0;
    rst_n           = 1'b0;
    otp_valid       = 1'b0;
    r               = '0;
    drive_row(r);

    // Every class with no unlock source
    rows.push_back(make_row(LcStRaw, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    rows.push_back(make_row(LcStTestLocked0, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    rows.push_back(make_row(LcStTestLocked6, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    rows.push_back(make_row(LcStTestUnlocked0, 1'b0, DevUnprovisioned, 1'b0, 1'b0, 1'b0));
    rows.push_back(make_row(LcStTestUnlocked7, 1'b0, DevUnprovisioned, 1'b0, 1'b0, 1'b0));
    rows.push_back(make_row(LcStDev, 1'b0, DevManufacturing, 1'b1, 1'b0, 1'b0));
    rows.push_back(make_row(LcStProd, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    rows.push_back(make_row(LcStProdEnd, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    rows.push_back(make_row(LcStRma, 1'b0, DevProduction, 1'b0, 1'b0, 1'b0));
    rows.push_back(make_row(LcStScrap, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    // Invalid code parks in idle
    rows.push_back(make_row(5'd25, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0));
    // Debug unlocks
    rows.push_back(make_row(LcStDev, 1'b1, DevManufacturing, 1'b0, 1'b0, 1'b0));
    r          = make_row(LcStProd, 1'b0, DevProduction, 1'b0, 1'b0, 1'b0);
    r.unlock   = 64'h10;
    r.dbg_mask = 64'hf0;
    rows.push_back(r);
    // Kill sources lock an unlocked class
    r       = make_row(LcStRma, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0);
    r.error = 1'b1;
    rows.push_back(r);
    r            = make_row(LcStTestUnlocked3, 1'b0, DevProduction, 1'b1, 1'b0, 1'b0);
    r.dft_en     = LcTxOn;
    r.hw_en      = LcTxOn;
    r.prog_req   = 1'b1;
    r.prog_state = LcStScrap;
    rows.push_back(r);
    // Program request to a non-scrap state is harmless
    r            = make_row(LcStRma, 1'b0, DevProduction, 1'b0, 1'b1, 1'b1);
    r.dft_en     = LcTxOn;
    r.hw_en      = LcTxOn;
    r.prog_req   = 1'b1;
    r.prog_state = LcStRma;
    rows.push_back(r);
    // Only the exact on code enables
    r          = make_row(LcStRaw, 1'b0, DevProduction, 1'b1, 1'b1, 1'b0);
    r.dft_en   = LcTxOn;
    r.hw_en    = 4'b1010;
    rows.push_back(r);
    // Random masks where m hits itself and never its complement
    m            = {$random(seed), $random(seed)} | 64'h1;
    r            = make_row(LcStProd, 1'b0, DevProduction, 1'b1, 1'b1, 1'b0);
    r.unlock     = m;
    r.dft_mask   = m;
    r.cltap_mask = ~m;
    rows.push_back(r);
    m            = {$random(seed), $random(seed)} | 64'h1;
    r            = make_row(LcStProd, 1'b0, DevProduction, 1'b0, 1'b0, 1'b1);
    r.unlock     = m;
    r.dft_mask   = ~m;
    r.cltap_mask = m;
    r.dbg_mask   = m;
    rows.push_back(r);

    // Reset for 3 cycles
    wait_edges(3);
    rst_n = 1'b1;

    foreach (rows[i]) begin
      row_idx   = i;
      r         = rows[i];
      @(negedge clk);
      otp_valid = 1'b0;
      wait_reset_values();
      check_lifecycle("lifecycle_o", lifecycle, DevProduction);
      check_bit("debug_locked_o", debug_locked, 1'b1);
      check_bit("soc_dft_en_o", soc_dft_en, 1'b0);
      check_bit("soc_hw_debug_en_o", soc_hw_debug_en, 1'b0);
      drive_row(r);
      otp_valid = 1'b1;
      // Constant inputs settle by edge 5
      wait_edges(5);
      check_lifecycle("lifecycle_o", lifecycle, r.exp_lc);
      check_bit("debug_locked_o", debug_locked, r.exp_locked);
      check_bit("soc_dft_en_o", soc_dft_en, r.exp_dft);
      check_bit("soc_hw_debug_en_o", soc_hw_debug_en, r.exp_hw);
      // A state error mid-row sends any class to production locked
      state_error = 1'b1;
      wait_edges(2);
      check_lifecycle("lifecycle_o", lifecycle, DevProduction);
      check_bit("debug_locked_o", debug_locked, 1'b1);
      // Clearing the kill sources keeps the class locked
      state_error = 1'b0;
      lc_prog_req = 1'b0;
      wait_edges(3);
      check_lifecycle("lifecycle_o", lifecycle, DevProduction);
      check_bit("debug_locked_o", debug_locked, 1'b1);
    end

    @(negedge clk);
    otp_valid = 1'b0;
    wait_reset_values();
    verdict_printed = 1'b1;
    $display("TEST PASS");
    $finish;
  end

  final begin
    if (!verdict_printed) begin
      $display("TEST FAIL");
    end
  end

endmodule

`default_nettype wire
